// File: rtl/divsqrt_pkg.sv
package divsqrt_pkg;

  // Operand, result and tag widths
  localparam int unsigned DATA_W = 32;
  localparam int unsigned TAG_W  = 4;

  // Divide makes one quotient bit per cycle and sqrt one root bit per cycle
  localparam int unsigned DIV_CYCLES  = 32;
  localparam int unsigned SQRT_CYCLES = 16;

  // Iteration counter wide enough for DIV_CYCLES
  localparam int unsigned CNT_W = 6;

  typedef enum logic {
    OP_DIV,
    OP_SQRT
  } divsqrt_op_e;

  // Controller states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_HOLD
  } divsqrt_state_e;

  // Flags for a zero divisor and for a non-zero final remainder
  typedef struct packed {
    logic div_zero;
    logic inexact;
  } divsqrt_status_t;

endpackage

// File: rtl/divsqrt_op_if.sv
`timescale 1ns/1ps

// One operation travelling from the input stage to the controller
interface divsqrt_op_if
  import divsqrt_pkg::*;
();

  logic              valid;
  logic              ready;
  divsqrt_op_e       op;
  logic [DATA_W-1:0] opa;
  logic [DATA_W-1:0] opb;
  logic [TAG_W-1:0]  tag;

  modport src (output valid, output op, output opa, output opb, output tag, input ready);

  modport dst (input valid, input op, input opa, input opb, input tag, output ready);

endinterface

// File: rtl/divsqrt_res_if.sv
`timescale 1ns/1ps

// One finished result travelling from the controller to the output stage
interface divsqrt_res_if
  import divsqrt_pkg::*;
();

  logic              valid;
  logic              ready;
  logic [DATA_W-1:0] result;
  divsqrt_status_t   status;
  logic [TAG_W-1:0]  tag;

  modport src (output valid, output result, output status, output tag, input ready);

  modport dst (input valid, input result, input status, input tag, output ready);

endinterface

// File: rtl/divsqrt_in_stage.sv
`timescale 1ns/1ps

module divsqrt_in_stage
  import divsqrt_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              flush_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  divsqrt_op_e       op_i,
  input  logic [DATA_W-1:0] opa_i,
  input  logic [DATA_W-1:0] opb_i,
  input  logic [TAG_W-1:0]  tag_i,
  divsqrt_op_if.src         op
);

  logic              valid_q;
  divsqrt_op_e       op_q;
  logic [DATA_W-1:0] opa_q;
  logic [DATA_W-1:0] opb_q;
  logic [TAG_W-1:0]  tag_q;

  // Room when empty or when the controller takes the current entry
  assign in_ready_o = op.ready | ~valid_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  // Payload only moves on an accepted transfer
  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      op_q  <= op_i;
      opa_q <= opa_i;
      opb_q <= opb_i;
      tag_q <= tag_i;
    end
  end

  assign op.valid = valid_q;
  assign op.op    = op_q;
  assign op.opa   = opa_q;
  assign op.opb   = opb_q;
  assign op.tag   = tag_q;

endmodule

// File: rtl/divsqrt_iter_core.sv
`timescale 1ns/1ps

module divsqrt_iter_core
  import divsqrt_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              flush_i,
  input  logic              start_i,
  input  divsqrt_op_e       op_i,
  input  logic [DATA_W-1:0] opa_i,
  input  logic [DATA_W-1:0] opb_i,
  output logic              done_o,
  output logic [DATA_W-1:0] result_o,
  output divsqrt_status_t   status_o
);

  logic [CNT_W-1:0]  cnt_q;
  logic              done_q;
  divsqrt_op_e       op_q;
  logic              div_zero_q;
  logic [DATA_W-1:0] rem_q, work_q, quo_q, den_q;

  divsqrt_op_e       op_cur;
  logic [DATA_W-1:0] rem_cur, work_cur, quo_cur, den_cur;
  logic [DATA_W+1:0] rem_sh, trial, diff;
  logic              take;

  // The start cycle already performs the first step on the fresh operands
  always_comb begin
    if (start_i) begin
      op_cur   = op_i;
      rem_cur  = '0;
      work_cur = opa_i;
      quo_cur  = '0;
      den_cur  = opb_i;
    end else begin
      op_cur   = op_q;
      rem_cur  = rem_q;
      work_cur = work_q;
      quo_cur  = quo_q;
      den_cur  = den_q;
    end
  end

  // One restoring step on a subtractor shared by both opcodes
  always_comb begin
    if (op_cur == OP_DIV) begin
      rem_sh = {1'b0, rem_cur, work_cur[DATA_W-1]};
      trial  = {2'b00, den_cur};
    end else begin
      // Shift in two radicand bits and try 4*root + 1
      rem_sh = {rem_cur, work_cur[DATA_W-1 -: 2]};
      trial  = {quo_cur, 2'b01};
    end
    diff = rem_sh - trial;
    take = ~diff[DATA_W+1];
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else if (flush_i) begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else if (start_i) begin
      cnt_q  <= (op_i == OP_DIV) ? CNT_W'(DIV_CYCLES - 1) : CNT_W'(SQRT_CYCLES - 1);
      done_q <= 1'b0;
    end else if (cnt_q != '0) begin
      cnt_q  <= cnt_q - 1'b1;
      done_q <= (cnt_q == CNT_W'(1));
    end else begin
      done_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      op_q       <= op_i;
      den_q      <= opb_i;
      div_zero_q <= (op_i == OP_DIV) && (opb_i == '0);
    end
    if (start_i || (cnt_q != '0)) begin
      rem_q  <= take ? diff[DATA_W-1:0] : rem_sh[DATA_W-1:0];
      work_q <= (op_cur == OP_DIV) ? (work_cur << 1) : (work_cur << 2);
      quo_q  <= {quo_cur[DATA_W-2:0], take};
    end
  end

  assign done_o            = done_q;
  assign result_o          = quo_q;
  assign status_o.div_zero = div_zero_q;
  assign status_o.inexact  = |rem_q;

endmodule

// File: rtl/divsqrt_ctrl.sv
`timescale 1ns/1ps

module divsqrt_ctrl
  import divsqrt_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              flush_i,
  divsqrt_op_if.dst         op,
  divsqrt_res_if.src        res,
  output logic              core_start_o,
  input  logic              core_done_i,
  input  logic [DATA_W-1:0] core_result_i,
  input  divsqrt_status_t   core_status_i,
  output logic              busy_o
);

  divsqrt_state_e   state_q, state_d;
  logic [TAG_W-1:0] tag_q;
  logic             res_taken;

  always_comb begin
    state_d   = state_q;
    op.ready  = 1'b0;
    res.valid = 1'b0;

    case (state_q)
      ST_IDLE: begin
        op.ready = 1'b1;
      end
      ST_BUSY: begin
        res.valid = core_done_i;
      end
      ST_HOLD: begin
        // Core keeps its result until the next start
        res.valid = 1'b1;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase

    res_taken = res.valid & res.ready;

    // Back-to-back start once the current result leaves
    if (res_taken) begin
      op.ready = 1'b1;
      state_d  = ST_IDLE;
    end else if (res.valid) begin
      state_d = ST_HOLD;
    end

    if (op.valid && op.ready) begin
      state_d = ST_BUSY;
    end

    if (flush_i) begin
      op.ready  = 1'b0;
      res.valid = 1'b0;
      state_d   = ST_IDLE;
    end
  end

  assign core_start_o = op.valid & op.ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (core_start_o) begin
      tag_q <= op.tag;
    end
  end

  assign res.result = core_result_i;
  assign res.status = core_status_i;
  assign res.tag    = tag_q;

  assign busy_o = (state_q != ST_IDLE);

endmodule

// File: rtl/divsqrt_out_stage.sv
`timescale 1ns/1ps

module divsqrt_out_stage
  import divsqrt_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              flush_i,
  divsqrt_res_if.dst        res,
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output logic [DATA_W-1:0] result_o,
  output divsqrt_status_t   status_o,
  output logic [TAG_W-1:0]  tag_o
);

  logic              valid_q;
  logic [DATA_W-1:0] result_q;
  divsqrt_status_t   status_q;
  logic [TAG_W-1:0]  tag_q;

  assign res.ready = out_ready_i | ~valid_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (res.ready) begin
      valid_q <= res.valid;
    end
  end

  // Held steady while the consumer stalls
  always_ff @(posedge clk_i) begin
    if (res.valid && res.ready) begin
      result_q <= res.result;
      status_q <= res.status;
      tag_q    <= res.tag;
    end
  end

  assign out_valid_o = valid_q;
  assign result_o    = result_q;
  assign status_o    = status_q;
  assign tag_o       = tag_q;

endmodule

// File: rtl/divsqrt_top.sv
`timescale 1ns/1ps

module divsqrt_top
  import divsqrt_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              flush_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  divsqrt_op_e       op_i,
  input  logic [DATA_W-1:0] opa_i,
  input  logic [DATA_W-1:0] opb_i,
  input  logic [TAG_W-1:0]  tag_i,
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output logic [DATA_W-1:0] result_o,
  output divsqrt_status_t   status_o,
  output logic [TAG_W-1:0]  tag_o,
  output logic              busy_o
);

  logic              core_start;
  logic              core_done;
  logic [DATA_W-1:0] core_result;
  divsqrt_status_t   core_status;
  logic              ctrl_busy;

  divsqrt_op_if  op_if ();
  divsqrt_res_if res_if ();

  divsqrt_in_stage u_in_stage (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .flush_i    (flush_i),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .op_i       (op_i),
    .opa_i      (opa_i),
    .opb_i      (opb_i),
    .tag_i      (tag_i),
    .op         (op_if.src)
  );

  divsqrt_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .op            (op_if.dst),
    .res           (res_if.src),
    .core_start_o  (core_start),
    .core_done_i   (core_done),
    .core_result_i (core_result),
    .core_status_i (core_status),
    .busy_o        (ctrl_busy)
  );

  // Core operands come straight from the input stage register
  divsqrt_iter_core u_core (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .flush_i  (flush_i),
    .start_i  (core_start),
    .op_i     (op_if.op),
    .opa_i    (op_if.opa),
    .opb_i    (op_if.opb),
    .done_o   (core_done),
    .result_o (core_result),
    .status_o (core_status)
  );

  divsqrt_out_stage u_out_stage (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .res         (res_if.dst),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .result_o    (result_o),
    .status_o    (status_o),
    .tag_o       (tag_o)
  );

  // Anything in flight anywhere keeps the unit busy
  assign busy_o = op_if.valid | ctrl_busy | out_valid_o;

endmodule

// File: tests/divsqrt_tb.sv
`timescale 1ns/1ps

module divsqrt_tb
  import divsqrt_pkg::*;
();

  localparam int ACCEPT_TIMEOUT = 500;
  localparam int DRAIN_TIMEOUT  = 2000;

  typedef struct packed {
    logic [DATA_W-1:0] result;
    logic [TAG_W-1:0]  tag;
    logic              div_zero;
    logic              inexact;
    logic              check_inexact;
  } expected_t;

  logic              clk_i;
  logic              rst_n_i;
  logic              flush_i;
  logic              in_valid_i;
  logic              in_ready_o;
  divsqrt_op_e       op_i;
  logic [DATA_W-1:0] opa_i;
  logic [DATA_W-1:0] opb_i;
  logic [TAG_W-1:0]  tag_i;
  logic              out_valid_o;
  logic              out_ready_i;
  logic [DATA_W-1:0] result_o;
  divsqrt_status_t   status_o;
  logic [TAG_W-1:0]  tag_o;
  logic              busy_o;

  expected_t         exp_q[$];
  integer            seed;
  int                checks;
  int                errors;
  int                test_checks;
  int                test_errors;
  logic [TAG_W-1:0]  next_tag;
  logic              bp_random;
  logic              stalled;
  logic [DATA_W-1:0] held_result;
  divsqrt_status_t   held_status;
  logic [TAG_W-1:0]  held_tag;

  divsqrt_top dut (.*);

  always #4 clk_i = ~clk_i;

  // Behavioral model of both operations
  function automatic expected_t model_op(input divsqrt_op_e op, input logic [31:0] a,
                                         input logic [31:0] b, input logic [3:0] tag);
    expected_t       e;
    longint unsigned r;
    e.tag           = tag;
    e.div_zero      = 1'b0;
    e.check_inexact = 1'b1;
    if (op == OP_SQRT) begin
      r = $rtoi($sqrt(real'(a)));
      while (r * r > a) r--;
      while ((r + 1) * (r + 1) <= a) r++;
      e.result  = r[31:0];
      e.inexact = (r * r != a);
    end else if (b == 0) begin
      // Remainder has no meaning here
      e.result        = '1;
      e.div_zero      = 1'b1;
      e.inexact       = 1'b0;
      e.check_inexact = 1'b0;
    end else begin
      e.result  = a / b;
      e.inexact = (a % b) != 0;
    end
    return e;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    checks++;
    assert (act_v === exp_v) else begin
      $display("[ERROR] %0t ns %0s expected %h actual %h", $time, name, exp_v, act_v);
      errors++;
    end
  endtask

  // Advance to the next falling edge and pick a fresh out_ready_i under back-pressure
  task automatic tick();
    logic [31:0] rnd;
    @(negedge clk_i);
    if (bp_random) begin
      rnd = $random(seed);
      out_ready_i = rnd[0];
    end else begin
      out_ready_i = 1'b1;
    end
  endtask

  task automatic send_op(input divsqrt_op_e op, input logic [31:0] a, input logic [31:0] b);
    int   waited;
    logic accepted;
    waited   = 0;
    accepted = 1'b0;
    tick();
    in_valid_i = 1'b1;
    op_i       = op;
    opa_i      = a;
    opb_i      = b;
    tag_i      = next_tag;
    while (!accepted && waited < ACCEPT_TIMEOUT) begin
      @(posedge clk_i);
      if (in_ready_o) begin
        accepted = 1'b1;
        exp_q.push_back(model_op(op, a, b, next_tag));
      end else begin
        waited++;
        tick();
      end
    end
    if (!accepted) begin
      $display("%0t ns: operation with tag %0d was never accepted", $time, next_tag);
      errors++;
    end
    next_tag++;
    tick();
    in_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
      tick();
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("%0t ns: %0d results never came out", $time, exp_q.size());
      errors++;
    end
  endtask

  task automatic begin_test();
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic end_test(input string name);
    $display("Test %0s: %0d checks, %0d errors", name, checks - test_checks,
             errors - test_errors);
  endtask

  // Scoreboard compare and hold check on every rising edge
  always @(posedge clk_i) begin
    expected_t e;
    if (!rst_n_i) begin
      stalled = 1'b0;
    end else begin
      if (stalled) begin
        check_value("out_valid_o (held)", 1, out_valid_o);
        check_value("result_o (held)", held_result, result_o);
        check_value("status_o (held)", held_status, status_o);
        check_value("tag_o (held)", held_tag, tag_o);
      end
      if (out_valid_o && out_ready_i) begin
        checks++;
        assert (exp_q.size() > 0) else begin
          $display("%0t ns: result with tag %0d came out with none expected", $time, tag_o);
          errors++;
        end
        if (exp_q.size() > 0) begin
          e = exp_q.pop_front();
          check_value("tag_o", e.tag, tag_o);
          check_value("result_o", e.result, result_o);
          check_value("status_o.div_zero", e.div_zero, status_o.div_zero);
          if (e.check_inexact) check_value("status_o.inexact", e.inexact, status_o.inexact);
        end
      end
      stalled     = out_valid_o && !out_ready_i;
      held_result = result_o;
      held_status = status_o;
      held_tag    = tag_o;
    end
  end

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] k;
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    flush_i     = 1'b0;
    in_valid_i  = 1'b0;
    op_i        = OP_DIV;
    opa_i       = '0;
    opb_i       = '0;
    tag_i       = '0;
    out_ready_i = 1'b1;
    seed        = 18768;
    checks      = 0;
    errors      = 0;
    next_tag    = '0;
    bp_random   = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_n_i = 1'b1;

    begin_test();
    tick();
    check_value("out_valid_o", 0, out_valid_o);
    check_value("busy_o", 0, busy_o);
    check_value("in_ready_o", 1, in_ready_o);
    end_test("reset_state");

    begin_test();
    for (int i = 0; i < 20; i++) begin
      a = $random(seed);
      b = $random(seed);
      b = b >> ($unsigned($random(seed)) % 32);
      if (b == 0) b = 1;
      // Every fourth one divides exactly
      if (i % 4 == 0) a = b * ($unsigned($random(seed)) % 1000);
      send_op(OP_DIV, a, b);
    end
    wait_drain();
    end_test("random_divisions");

    begin_test();
    send_op(OP_DIV, 32'd12345, 32'd0);
    send_op(OP_DIV, 32'd0, 32'd0);
    send_op(OP_DIV, $random(seed), 32'd0);
    wait_drain();
    end_test("divide_by_zero");

    begin_test();
    send_op(OP_SQRT, 32'd0, 32'd0);
    send_op(OP_SQRT, 32'hFFFF_FFFF, 32'd7);
    send_op(OP_SQRT, 32'hFFFE_0001, 32'd0);
    for (int i = 0; i < 16; i++) begin
      a = $random(seed);
      k = $unsigned($random(seed)) & 32'h0000_FFFF;
      send_op(OP_SQRT, (i % 2 == 0) ? a : k * k, $random(seed));
    end
    wait_drain();
    end_test("square_roots");

    begin_test();
    bp_random = 1'b1;
    for (int i = 0; i < 16; i++) begin
      a = $random(seed);
      b = $unsigned($random(seed)) >> ($unsigned($random(seed)) % 32);
      send_op((a[0]) ? OP_SQRT : OP_DIV, a, b);
    end
    wait_drain();
    bp_random = 1'b0;
    tick();
    end_test("back_pressure");

    begin_test();
    send_op(OP_DIV, 32'd1000, 32'd7);
    repeat (5) tick();
    check_value("busy_o", 1, busy_o);
    flush_i = 1'b1;
    exp_q.delete();
    tick();
    flush_i = 1'b0;
    check_value("busy_o", 0, busy_o);
    repeat (60) tick();
    check_value("out_valid_o", 0, out_valid_o);
    send_op(OP_SQRT, 32'd1_000_000, 32'd0);
    wait_drain();
    end_test("flush");

    $display("Totals: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: list.f
rtl/divsqrt_pkg.sv
rtl/divsqrt_op_if.sv
rtl/divsqrt_res_if.sv
rtl/divsqrt_in_stage.sv
rtl/divsqrt_iter_core.sv
rtl/divsqrt_ctrl.sv
rtl/divsqrt_out_stage.sv
rtl/divsqrt_top.sv
tests/divsqrt_tb.sv
